// ==== logic/duck_flight.sv ====
`default_nettype none

module duck_flight #(
    parameter int STEP_CYCLES = 65_000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                hunting,
    input  logic                duck_killed,
    input  logic                restart,
    output duck_pkg::duck_pos_t duck_pos
);

    import duck_pkg::*;

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    // top-left corner limits so the whole box stays on screen
    localparam coord_t X_MAX = FIELD_W - DUCK_W - 1;
    localparam coord_t Y_MAX = FIELD_H - DUCK_H - 1;
    localparam coord_t X_CTR = (FIELD_W - DUCK_W) / 2;
    localparam coord_t Y_CTR = (FIELD_H - DUCK_H) / 2;

    logic [CNT_W-1:0] step_cnt;
    logic             step_tick;
    logic             dir_right;  // 1 moves towards larger x
    logic             dir_down;   // 1 moves towards larger y

    // one pixel along an axis, turning around at 0 and at lim
    // returns {new direction, new position}
    function automatic logic [12:0] bounce(
        input coord_t pos,
        input logic   fwd,
        input coord_t lim
    );
        logic   dir;
        coord_t nxt;
        dir = fwd;
        if (fwd) begin
            if (pos >= lim) begin
                dir = 1'b0;
                nxt = pos - 1'b1;
            end else begin
                nxt = pos + 1'b1;
            end
        end else begin
            if (pos == '0) begin
                dir = 1'b1;
                nxt = pos + 1'b1;
            end else begin
                nxt = pos - 1'b1;
            end
        end
        return {dir, nxt};
    endfunction

    // ------------------------------------------------------------------
    // step timing
    // ------------------------------------------------------------------
    assign step_tick = hunting && (step_cnt == CNT_W'(STEP_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt <= '0;
        end else if (!hunting || step_tick) begin
            step_cnt <= '0;  // no motion outside hunting
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // position and direction
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            dir_right  <= 1'b1;
            dir_down   <= 1'b1;
            duck_pos.x <= X_CTR;
            duck_pos.y <= Y_CTR;
        end else if (restart || duck_killed) begin
            // new duck starts from the middle
            duck_pos.x <= X_CTR;
            duck_pos.y <= Y_CTR;
        end else if (step_tick) begin
            {dir_right, duck_pos.x} <= bounce(duck_pos.x, dir_right, X_MAX);
            {dir_down, duck_pos.y}  <= bounce(duck_pos.y, dir_down, Y_MAX);
        end
    end

    // box never leaves the playfield, whatever the step timing
    a_box_in_field: assert property (@(posedge clk) disable iff (rst)
        (int'(duck_pos.x) + int'(DUCK_W) < int'(FIELD_W)) &&
        (int'(duck_pos.y) + int'(DUCK_H) < int'(FIELD_H)));

endmodule

`default_nettype wire

// ==== logic/duck_hunt_core.sv ====
`default_nettype none

module duck_hunt_core #(
    parameter int COUNTDOWN   = 130_000_000,
    parameter int DEATH_TIME  = 130_000_000,
    parameter int RELOAD_TIME = 65_000,
    parameter int STEP_CYCLES = 65_000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  duck_pkg::coord_t       mouse_x,
    input  duck_pkg::coord_t       mouse_y,
    input  logic                   left_button,
    input  logic                   right_button,
    input  logic                   game_enable,
    output duck_pkg::duck_pos_t    duck,
    output duck_pkg::game_status_t status
);

    import duck_pkg::*;

    shot_t shot;     // click pulses into the game
    logic  hunting;
    logic  restart;  // new game started

    // ------------------------------------------------------------------
    // duck motion
    // ------------------------------------------------------------------
    duck_flight #(
        .STEP_CYCLES(STEP_CYCLES)
    ) duck_flight_inst (
        .clk        (clk),
        .rst        (rst),
        .hunting    (hunting),
        .duck_killed(status.duck_killed),
        .restart    (restart),
        .duck_pos   (duck)
    );

    shot_detector shot_detector_inst (
        .clk         (clk),
        .rst         (rst),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .left_button (left_button),
        .right_button(right_button),
        .duck_pos    (duck),
        .shot        (shot)
    );

    // ------------------------------------------------------------------
    // game control
    // ------------------------------------------------------------------
    game_fsm #(
        .COUNTDOWN  (COUNTDOWN),
        .DEATH_TIME (DEATH_TIME),
        .RELOAD_TIME(RELOAD_TIME)
    ) game_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .game_enable(game_enable),
        .shot       (shot),
        .restart    (restart),
        .hunting    (hunting),
        .status     (status)
    );

endmodule

`default_nettype wire

// ==== logic/duck_pkg.sv ====
`default_nettype none

package duck_pkg;

    // ------------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------------
    typedef logic [11:0] coord_t;  // pixel coordinate

    localparam coord_t FIELD_W = 12'd640;
    localparam coord_t FIELD_H = 12'd480;

    // duck box spans x .. x+DUCK_W and y .. y+DUCK_H, both ends included
    localparam coord_t DUCK_W = 12'd96;
    localparam coord_t DUCK_H = 12'd60;

    // ------------------------------------------------------------------
    // ammunition
    // ------------------------------------------------------------------
    localparam logic [2:0] MAG_SIZE     = 3'd3;   // rounds per magazine
    localparam logic [6:0] RESERVE_INIT = 7'd27;  // spare rounds at game start

    // click pulses from the mouse, one cycle each
    typedef struct packed {
        logic fire;    // left button edge
        logic reload;  // right button edge
        logic hit;     // cursor inside duck box at fire
    } shot_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } duck_pos_t;

    // everything the display side needs from the game
    typedef struct packed {
        logic [2:0] magazine;
        logic [6:0] reserve;
        logic [6:0] score;
        logic       hunting;
        logic       reload_needed;  // empty click seen
        logic       duck_killed;    // one-cycle pulse
        logic       game_over;
    } game_status_t;

endpackage

`default_nettype wire

// ==== logic/game_fsm.sv ====
`default_nettype none

module game_fsm #(
    parameter int COUNTDOWN   = 130_000_000,
    parameter int DEATH_TIME  = 130_000_000,
    parameter int RELOAD_TIME = 65_000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   game_enable,
    input  duck_pkg::shot_t        shot,
    output logic                   restart,
    output logic                   hunting,
    output duck_pkg::game_status_t status
);

    import duck_pkg::*;

    // timer start values, the timer runs down to zero inclusive
    localparam logic [31:0] COUNTDOWN_LOAD = (COUNTDOWN > 1) ? COUNTDOWN - 1 : 0;
    localparam logic [31:0] DEATH_LOAD     = (DEATH_TIME > 1) ? DEATH_TIME - 1 : 0;
    localparam logic [31:0] RELOAD_LOAD    = (RELOAD_TIME > 1) ? RELOAD_TIME - 1 : 0;

    typedef enum logic [1:0] {
        ST_WAIT   = 2'b00,
        ST_HUNT   = 2'b01,
        ST_RELOAD = 2'b10,
        ST_DELAY  = 2'b11
    } state_t;

    state_t      state;
    state_t      state_nxt;
    logic [31:0] timer;
    logic [31:0] timer_nxt;
    logic [2:0]  magazine;
    logic [2:0]  magazine_nxt;
    logic [6:0]  reserve;
    logic [6:0]  reserve_nxt;
    logic [6:0]  score;
    logic [6:0]  score_nxt;
    logic        reload_needed;
    logic        reload_needed_nxt;
    logic        duck_killed;
    logic        duck_killed_nxt;
    logic        game_over;
    logic        game_over_nxt;
    logic        restart_nxt;
    logic [2:0]  missing;  // empty slots in the magazine
    logic [2:0]  refill;   // rounds moved on a reload

    // ------------------------------------------------------------------
    // reload amount
    // ------------------------------------------------------------------
    assign missing = MAG_SIZE - magazine;
    assign refill  = (reserve < 7'(missing)) ? reserve[2:0] : missing;  // partial near the end

    // ------------------------------------------------------------------
    // next state and counters
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt         = state;
        timer_nxt         = timer;
        magazine_nxt      = magazine;
        reserve_nxt       = reserve;
        score_nxt         = score;
        reload_needed_nxt = reload_needed;
        game_over_nxt     = game_over;
        duck_killed_nxt   = 1'b0;
        restart_nxt       = 1'b0;

        case (state)
            ST_WAIT: begin
                // after game over the enable has to drop before a new game
                if (!game_enable) begin
                    game_over_nxt = 1'b0;
                end else if (!game_over) begin
                    state_nxt         = ST_DELAY;
                    timer_nxt         = COUNTDOWN_LOAD;
                    magazine_nxt      = MAG_SIZE;
                    reserve_nxt       = RESERVE_INIT;
                    score_nxt         = '0;
                    reload_needed_nxt = 1'b0;
                    restart_nxt       = 1'b1;
                end
            end

            ST_DELAY, ST_RELOAD: begin
                if (timer == '0) begin
                    state_nxt = ST_HUNT;
                end else begin
                    timer_nxt = timer - 1'b1;
                end
            end

            ST_HUNT: begin
                if (shot.reload) begin  // reload wins over a same-cycle fire
                    state_nxt         = ST_RELOAD;
                    timer_nxt         = RELOAD_LOAD;
                    magazine_nxt      = magazine + refill;
                    reserve_nxt       = reserve - 7'(refill);
                    reload_needed_nxt = 1'b0;
                end else if (shot.fire) begin
                    if (magazine == '0) begin
                        reload_needed_nxt = 1'b1;  // click on empty
                    end else begin
                        magazine_nxt = magazine - 1'b1;
                        if (shot.hit) begin
                            score_nxt       = score + 1'b1;
                            duck_killed_nxt = 1'b1;
                            state_nxt       = ST_DELAY;
                            timer_nxt       = DEATH_LOAD;
                        end
                        // last round gone with nothing in reserve
                        if (magazine == 3'd1 && reserve == '0) begin
                            game_over_nxt = 1'b1;
                            state_nxt     = ST_WAIT;
                        end
                    end
                end
            end

            default: state_nxt = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_WAIT;
            timer         <= '0;
            magazine      <= MAG_SIZE;
            reserve       <= RESERVE_INIT;
            score         <= '0;
            reload_needed <= 1'b0;
            duck_killed   <= 1'b0;
            game_over     <= 1'b0;
            restart       <= 1'b0;
        end else begin
            state         <= state_nxt;
            timer         <= timer_nxt;
            magazine      <= magazine_nxt;
            reserve       <= reserve_nxt;
            score         <= score_nxt;
            reload_needed <= reload_needed_nxt;
            duck_killed   <= duck_killed_nxt;
            game_over     <= game_over_nxt;
            restart       <= restart_nxt;
        end
    end

    // ------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------
    assign hunting = (state == ST_HUNT);

    assign status = '{
        magazine:      magazine,
        reserve:       reserve,
        score:         score,
        hunting:       hunting,
        reload_needed: reload_needed,
        duck_killed:   duck_killed,
        game_over:     game_over
    };

    a_mag_bound: assert property (@(posedge clk) disable iff (rst)
        magazine <= MAG_SIZE);

    // kill pulse must not stretch, the flight block re-centres on it
    a_kill_pulse: assert property (@(posedge clk) disable iff (rst)
        duck_killed |=> !duck_killed);

endmodule

`default_nettype wire

// ==== logic/shot_detector.sv ====
`default_nettype none

module shot_detector (
    input  logic                clk,
    input  logic                rst,
    input  duck_pkg::coord_t    mouse_x,
    input  duck_pkg::coord_t    mouse_y,
    input  logic                left_button,
    input  logic                right_button,
    input  duck_pkg::duck_pos_t duck_pos,
    output duck_pkg::shot_t     shot
);

    import duck_pkg::*;

    // bit 0 is the left button, bit 1 the right one
    logic [1:0] btn_q;
    logic [1:0] btn_prev;
    logic [1:0] btn_rise;
    logic       in_x;
    logic       in_y;

    // ------------------------------------------------------------------
    // button edges
    // ------------------------------------------------------------------
    assign btn_rise = btn_q & ~btn_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_q    <= '0;
            btn_prev <= '0;
        end else begin
            btn_q    <= {right_button, left_button};
            btn_prev <= btn_q;
        end
    end

    // ------------------------------------------------------------------
    // hit test against the duck box
    // ------------------------------------------------------------------
    // both box edges count as inside
    assign in_x = (mouse_x >= duck_pos.x) && (mouse_x <= duck_pos.x + DUCK_W);
    assign in_y = (mouse_y >= duck_pos.y) && (mouse_y <= duck_pos.y + DUCK_H);

    always_ff @(posedge clk) begin
        if (rst) begin
            shot <= '0;
        end else begin
            shot.fire   <= btn_rise[0];
            shot.reload <= btn_rise[1];
            shot.hit    <= btn_rise[0] && in_x && in_y;  // position at the click
        end
    end

    // a hit only ever comes with its own fire pulse
    a_hit_needs_fire: assert property (@(posedge clk) disable iff (rst)
        shot.hit |-> shot.fire);

endmodule

`default_nettype wire

// ==== tests/duck_hunt_tb.sv ====
`default_nettype none

module duck_hunt_tb;

    import duck_pkg::*;

    localparam int COUNTDOWN   = 40;
    localparam int DEATH_TIME  = 20;
    localparam int RELOAD_TIME = 4;
    localparam int STEP_CYCLES = 2;
    localparam int N_STEPS     = 25;
    localparam logic [31:0] SEED = 32'hfb140ee1;

    // long enough for the box to reach all four walls
    localparam int FLY_CYCLES  = 2 * STEP_CYCLES * int'(FIELD_W);

    localparam logic [1:0] ACT_MISS   = 2'd0;
    localparam logic [1:0] ACT_HIT    = 2'd1;
    localparam logic [1:0] ACT_RELOAD = 2'd2;
    localparam logic [1:0] ACT_EMPTY  = 2'd3;

    // reset, countdown, free flight, then up to three actions per step each with a full delay
    localparam int CYCLE_LIMIT = 8 + COUNTDOWN + FLY_CYCLES
                               + N_STEPS * 3 * (DEATH_TIME + RELOAD_TIME + 8) + 100;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [1:0]      act;
        logic [2:0]      reps;   // action repeated this often
        logic [2:0]      mag;
        logic [6:0]      res;
        logic [6:0]      score;
        logic            rn;     // reload_needed
        logic            over;   // game_over
    } step_t;

    logic         clk;
    logic         rst;
    coord_t       mouse_x;
    coord_t       mouse_y;
    logic         left_button;
    logic         right_button;
    logic         game_enable;
    duck_pos_t    duck;
    game_status_t status;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    logic  in_field;

    // ------------------------------------------------------------------
    // step table, expected counts after the step
    // ------------------------------------------------------------------
    step_t steps [N_STEPS] = '{
        '{"miss_a",      ACT_MISS,   3'd1, 3'd2, 7'd27, 7'd0, 1'b0, 1'b0},
        '{"hit_a",       ACT_HIT,    3'd1, 3'd1, 7'd27, 7'd1, 1'b0, 1'b0},
        '{"miss_b",      ACT_MISS,   3'd1, 3'd0, 7'd27, 7'd1, 1'b0, 1'b0},
        '{"empty_a",     ACT_EMPTY,  3'd1, 3'd0, 7'd27, 7'd1, 1'b1, 1'b0},
        '{"reload_a",    ACT_RELOAD, 3'd1, 3'd3, 7'd24, 7'd1, 1'b0, 1'b0},
        '{"hit_b",       ACT_HIT,    3'd1, 3'd2, 7'd24, 7'd2, 1'b0, 1'b0},
        '{"reload_b",    ACT_RELOAD, 3'd1, 3'd3, 7'd23, 7'd2, 1'b0, 1'b0},
        '{"drain_1",     ACT_MISS,   3'd3, 3'd0, 7'd23, 7'd2, 1'b0, 1'b0},
        '{"reload_c",    ACT_RELOAD, 3'd1, 3'd3, 7'd20, 7'd2, 1'b0, 1'b0},
        '{"drain_2",     ACT_MISS,   3'd3, 3'd0, 7'd20, 7'd2, 1'b0, 1'b0},
        '{"reload_d",    ACT_RELOAD, 3'd1, 3'd3, 7'd17, 7'd2, 1'b0, 1'b0},
        '{"drain_3",     ACT_MISS,   3'd3, 3'd0, 7'd17, 7'd2, 1'b0, 1'b0},
        '{"reload_e",    ACT_RELOAD, 3'd1, 3'd3, 7'd14, 7'd2, 1'b0, 1'b0},
        '{"drain_4",     ACT_MISS,   3'd3, 3'd0, 7'd14, 7'd2, 1'b0, 1'b0},
        '{"reload_f",    ACT_RELOAD, 3'd1, 3'd3, 7'd11, 7'd2, 1'b0, 1'b0},
        '{"drain_5",     ACT_MISS,   3'd3, 3'd0, 7'd11, 7'd2, 1'b0, 1'b0},
        '{"reload_g",    ACT_RELOAD, 3'd1, 3'd3, 7'd8,  7'd2, 1'b0, 1'b0},
        '{"drain_6",     ACT_MISS,   3'd3, 3'd0, 7'd8,  7'd2, 1'b0, 1'b0},
        '{"reload_h",    ACT_RELOAD, 3'd1, 3'd3, 7'd5,  7'd2, 1'b0, 1'b0},
        '{"drain_7",     ACT_MISS,   3'd3, 3'd0, 7'd5,  7'd2, 1'b0, 1'b0},
        '{"reload_i",    ACT_RELOAD, 3'd1, 3'd3, 7'd2,  7'd2, 1'b0, 1'b0},
        '{"drain_8",     ACT_MISS,   3'd3, 3'd0, 7'd2,  7'd2, 1'b0, 1'b0},
        '{"reload_part", ACT_RELOAD, 3'd1, 3'd2, 7'd0,  7'd2, 1'b0, 1'b0},
        '{"miss_c",      ACT_MISS,   3'd1, 3'd1, 7'd0,  7'd2, 1'b0, 1'b0},
        '{"hit_last",    ACT_HIT,    3'd1, 3'd0, 7'd0,  7'd3, 1'b0, 1'b1}
    };

    duck_hunt_core #(
        .COUNTDOWN  (COUNTDOWN),
        .DEATH_TIME (DEATH_TIME),
        .RELOAD_TIME(RELOAD_TIME),
        .STEP_CYCLES(STEP_CYCLES)
    ) duck_hunt_core_inst (
        .clk         (clk),
        .rst         (rst),
        .mouse_x     (mouse_x),
        .mouse_y     (mouse_y),
        .left_button (left_button),
        .right_button(right_button),
        .game_enable (game_enable),
        .duck        (duck),
        .status      (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic check(input logic [8*12-1:0] name, input string what,
                         input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("MISMATCH %0s %0s: expected %0d, actual %0d",
                     name, what, expected, actual);
        end
    endtask

    // phase lengths may land one cycle either side
    function automatic int tolerate_one(input int actual, input int expected);
        if (actual >= expected - 1 && actual <= expected + 1) begin
            return expected;
        end
        return actual;
    endfunction

    // one click at the current falling edge, returns once the status has updated
    task automatic click(input logic [1:0] act);
        duck_pos_t seen;
        int        off;
        seen = duck;
        off  = 200 + int'($urandom % 200);
        if (act == ACT_HIT) begin
            mouse_x = seen.x + 12'd10;
            mouse_y = seen.y + 12'd10;
        end else begin
            mouse_x = coord_t'((int'(seen.x) + off) % int'(FIELD_W));  // well clear of the box
            mouse_y = seen.y;
        end
        if (act == ACT_RELOAD) begin
            right_button = 1'b1;
        end else begin
            left_button = 1'b1;
        end
        @(negedge clk);
        left_button  = 1'b0;
        right_button = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // counts falling edges with hunting low
    task automatic wait_hunting(output int low);
        low = 0;
        while (!status.hunting && !status.game_over) begin
            low++;
            @(negedge clk);
        end
    endtask

    assign in_field = (int'(duck.x) + int'(DUCK_W) < int'(FIELD_W)) &&
                      (int'(duck.y) + int'(DUCK_H) < int'(FIELD_H));

    always @(negedge clk) begin
        if (!rst) begin
            check("monitor", "duck box in field", 1, int'(in_field));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: hunting never came back after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial begin
        int          low;
        int          errs_before;
        coord_t      x_lo;
        coord_t      x_hi;
        coord_t      y_lo;
        coord_t      y_hi;
        step_t       s;
        rst          = 1'b1;
        mouse_x      = '0;
        mouse_y      = '0;
        left_button  = 1'b0;
        right_button = 1'b0;
        game_enable  = 1'b0;
        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check("reset", "magazine", MAG_SIZE, status.magazine);
        check("reset", "reserve", RESERVE_INIT, status.reserve);
        check("reset", "score", 0, status.score);
        check("reset", "hunting", 0, status.hunting);
        $display("step reset: %0s", (errors == 0) ? "ok" : "failed");

        errs_before = errors;
        game_enable = 1'b1;
        @(negedge clk);
        wait_hunting(low);
        check("countdown", "cycles", COUNTDOWN, tolerate_one(low, COUNTDOWN));
        $display("step countdown: %0s", (errors == errs_before) ? "ok" : "failed");

        // free flight, the box has to touch every wall and turn back
        errs_before = errors;
        x_lo        = duck.x;
        x_hi        = duck.x;
        y_lo        = duck.y;
        y_hi        = duck.y;
        repeat (FLY_CYCLES) begin
            @(negedge clk);
            x_lo = (duck.x < x_lo) ? duck.x : x_lo;
            x_hi = (duck.x > x_hi) ? duck.x : x_hi;
            y_lo = (duck.y < y_lo) ? duck.y : y_lo;
            y_hi = (duck.y > y_hi) ? duck.y : y_hi;
        end
        check("flight", "left edge", 0, x_lo);
        check("flight", "right edge", int'(FIELD_W) - int'(DUCK_W) - 1, x_hi);
        check("flight", "top edge", 0, y_lo);
        check("flight", "bottom edge", int'(FIELD_H) - int'(DUCK_H) - 1, y_hi);
        check("flight", "hunting", 1, status.hunting);
        $display("step flight: %0s", (errors == errs_before) ? "ok" : "failed");

        for (int i = 0; i < N_STEPS; i++) begin
            s           = steps[i];
            errs_before = errors;
            for (int r = 0; r < int'(s.reps); r++) begin
                click(s.act);
                check(s.name, "kill pulse", int'(s.act == ACT_HIT), status.duck_killed);
                if (s.act == ACT_HIT || s.act == ACT_RELOAD) begin
                    check(s.name, "hunting dropped", 0, status.hunting);
                end
                wait_hunting(low);
                if (s.act == ACT_HIT && !s.over) begin
                    check(s.name, "kill delay", DEATH_TIME, tolerate_one(low, DEATH_TIME));
                end
                if (s.act == ACT_RELOAD) begin
                    check(s.name, "reload time", RELOAD_TIME, tolerate_one(low, RELOAD_TIME));
                end
            end
            check(s.name, "magazine", s.mag, status.magazine);
            check(s.name, "reserve", s.res, status.reserve);
            check(s.name, "score", s.score, status.score);
            check(s.name, "reload_needed", s.rn, status.reload_needed);
            check(s.name, "game_over", s.over, status.game_over);
            check(s.name, "hunting", int'(!s.over), status.hunting);
            $display("step %0s: %0s", s.name, (errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d steps run, %0d checks, %0d mismatches", N_STEPS + 3, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/duck_pkg.sv
logic/duck_flight.sv
logic/shot_detector.sv
logic/game_fsm.sv
logic/duck_hunt_core.sv
tests/duck_hunt_tb.sv
